//--- common/nora_consts.svh
`ifndef NORA_CONSTS_SVH
`define NORA_CONSTS_SVH

// bus widths
`define DATA_W           8
`define ADDR_W           16
`define MEM_AH_W         9       // memory address bits 20..12
`define BANK_W           8

// ram banking, x16 compatible
`define RAMBANK_MASK     8'h7F   // only 128 banks visible

// cpu address map
`define IO_BASE          16'h9F00    // whole 9Fxx page is i/o
`define VIA_BASE         16'h9F00    // 16 bytes
`define VIA_SIZE         16'd16
`define VERA_BASE        16'h9F20
`define VERA_END         16'h9F3F
`define BANKWIN_BASE     16'hA000    // banked ram window up to BFFF
`define ROM_BASE         16'hC000    // rom window, read only

// attention button timing, in clk6x cycles
`define DEBOUNCE_CYCLES  16
`define NMI_PULSE_CYCLES 12
`define BTN_CNT_W        5       // wide enough for both counts above

`endif

//--- common/nora_bus_pkg.sv
`include "nora_consts.svh"

package nora_bus_pkg;

    typedef logic [`DATA_W-1:0]   data_t;       // one byte on cpu or mem bus
    typedef logic [`ADDR_W-1:0]   cpu_addr_t;   // full 16b cpu address
    typedef logic [`MEM_AH_W-1:0] mem_ah_t;     // MA[20:12]
    typedef logic [`BANK_W-1:0]   bank_t;       // ram bank register

    // where a cpu cycle goes
    typedef enum logic [2:0]
    {
        TGT_NONE    = 3'd0,     // unused i/o, reads FF
        TGT_SRAM    = 3'd1,
        TGT_BANKREG = 3'd2,     // address 0000
        TGT_VIA     = 3'd3,
        TGT_VERA    = 3'd4      // external chip, drives cpu bus itself
    } bus_target_e;

endpackage

//--- common/nora_cpu_pkg.sv
package nora_cpu_pkg;

    // six clk6x phases per cpu cycle
    typedef enum logic [2:0]
    {
        PH_S0, PH_S1, PH_S2,    // phi2 low
        PH_S3, PH_S4, PH_S5     // phi2 high
    } phi_phase_e;

    // register select, cpu address bits 1..0
    typedef enum logic [1:0]
    {
        VIA_ORB  = 2'd0,
        VIA_ORA  = 2'd1,
        VIA_DDRB = 2'd2,
        VIA_DDRA = 2'd3
    } via_reg_e;

    typedef enum logic [1:0]
    {
        BTN_IDLE,
        BTN_DEBOUNCE,       // counting stable low samples
        BTN_PULSE,          // nmi held low
        BTN_WAIT_RELEASE    // counting stable high samples
    } btn_state_e;

endpackage

//--- phaser/phaser.sv
`timescale 1ns/1ps

module phaser import nora_cpu_pkg::*;
(
    input  logic clk6x,
    input  logic rst_n_i,
    output logic cpu_phi2_o,     // cpu clock, 1/6 of clk6x
    output logic latch_ad_o,     // high in S2, phi2 rises at its edge
    output logic setup_cs_o,     // high in S3
    output logic release_wr_o,   // high in S5
    output logic release_cs_o    // high in S0
);

    phi_phase_e phase_q;
    phi_phase_e phase_d;

    // free running, no stretching
    always_comb
    begin
        case (phase_q)
            PH_S0:   phase_d = PH_S1;
            PH_S1:   phase_d = PH_S2;
            PH_S2:   phase_d = PH_S3;
            PH_S3:   phase_d = PH_S4;
            PH_S4:   phase_d = PH_S5;
            default: phase_d = PH_S0;   // S5 wraps
        endcase
    end

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            phase_q <= PH_S0;
        end
        else
        begin
            phase_q <= phase_d;
        end
    end

    // outputs decoded from the next phase, so the flops line up with phase_q
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            cpu_phi2_o   <= 1'b0;
            latch_ad_o   <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            // phi2 high in S3..S5
            cpu_phi2_o   <= (phase_d == PH_S3) || (phase_d == PH_S4) || (phase_d == PH_S5);
            latch_ad_o   <= (phase_d == PH_S2);
            setup_cs_o   <= (phase_d == PH_S3);
            release_wr_o <= (phase_d == PH_S5);  // wr released one clock before cs
            // first S0 after reset has no strobe, nothing to release yet
            release_cs_o <= (phase_d == PH_S0);
        end
    end

endmodule

//--- busctrl/bus_controller.sv
`timescale 1ns/1ps
`include "nora_consts.svh"

module bus_controller import nora_bus_pkg::*, nora_cpu_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    // strobes from phaser
    input  logic      latch_ad_i,
    input  logic      setup_cs_i,
    input  logic      release_wr_i,
    input  logic      release_cs_i,
    // cpu bus
    input  cpu_addr_t cpu_a_i,
    input  logic      cpu_rwn_i,    // 1 = read
    input  data_t     cpu_d_i,
    output data_t     cpu_d_o,
    output logic      cpu_d_oe_o,
    // memory bus
    output mem_ah_t   mem_ah_o,
    input  data_t     mem_d_i,
    output data_t     mem_d_o,
    output logic      mem_d_oe_o,
    output logic      sram_csn_o,
    output logic      vera_csn_o,
    output logic      mem_rdn_o,
    output logic      mem_wrn_o,
    // internal via
    output via_reg_e  via_reg_o,
    output data_t     via_wdata_o,
    output logic      via_wr_o,
    output logic      via_sel_o,
    input  data_t     via_rdata_i
);

    bus_target_e tgt_d, tgt_q;
    mem_ah_t     ah_d;
    bank_t       bank_q;
    bank_t       bank_masked;
    logic        rom_d, rom_q;      // write protected window
    logic        rwn_q;
    logic        ext_q;             // target lives on the memory bus
    via_reg_e    via_reg_q;

    assign bank_masked = bank_q & `RAMBANK_MASK;

    // address decode and high address, from the live cpu address
    always_comb
    begin
        rom_d = (cpu_a_i >= `ROM_BASE);
        if (cpu_a_i == 16'h0000)
            tgt_d = TGT_BANKREG;
        else if ((cpu_a_i & 16'hFF00) == `IO_BASE)
        begin
            if (cpu_a_i >= `VIA_BASE && cpu_a_i < `VIA_BASE + `VIA_SIZE)
                tgt_d = TGT_VIA;
            else if (cpu_a_i >= `VERA_BASE && cpu_a_i <= `VERA_END)
                tgt_d = TGT_VERA;
            else
                tgt_d = TGT_NONE;       // hole in the io page
        end
        else
            tgt_d = TGT_SRAM;

        if (rom_d)
            ah_d = {5'b01000, cpu_a_i[15:12]};
        else if (cpu_a_i >= `BANKWIN_BASE)
            ah_d = {1'b1, bank_masked[6:0], cpu_a_i[12]};   // 8k banks
        else
            ah_d = {5'b00000, cpu_a_i[15:12]};              // low 40k, flat
    end

    // latch at phi2 rise
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            tgt_q <= TGT_NONE;
            rwn_q <= 1'b1;
        end
        else if (latch_ad_i)
        begin
            tgt_q <= tgt_d;
            rwn_q <= cpu_rwn_i;
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)
        begin
            mem_ah_o  <= ah_d;
            rom_q     <= rom_d;
            via_reg_q <= via_reg_e'(cpu_a_i[1:0]);   // regs alias over the 16 byte window
        end
    end

    assign ext_q = (tgt_q == TGT_SRAM) || (tgt_q == TGT_VERA);

    // cs/rd/wr sequencing: active S4..S5, cs and rd held through S0
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            sram_csn_o <= 1'b1;
            vera_csn_o <= 1'b1;
            mem_rdn_o  <= 1'b1;
            mem_wrn_o  <= 1'b1;
            cpu_d_oe_o <= 1'b0;
            mem_d_oe_o <= 1'b0;
        end
        else if (setup_cs_i)
        begin
            sram_csn_o <= (tgt_q != TGT_SRAM);
            vera_csn_o <= (tgt_q != TGT_VERA);
            mem_rdn_o  <= !(rwn_q && ext_q);
            mem_wrn_o  <= !(!rwn_q && tgt_q == TGT_SRAM && !rom_q);  // rom writes dropped
            cpu_d_oe_o <= rwn_q && (tgt_q != TGT_VERA);  // vera drives cd itself
            mem_d_oe_o <= !rwn_q && (tgt_q == TGT_SRAM);
        end
        else if (release_wr_i)
        begin
            mem_wrn_o  <= 1'b1;     // hold time before cs release
            cpu_d_oe_o <= 1'b0;
            mem_d_oe_o <= 1'b0;
        end
        else if (release_cs_i)
        begin
            sram_csn_o <= 1'b1;
            vera_csn_o <= 1'b1;
            mem_rdn_o  <= 1'b1;
        end
    end

    // bank register, write data valid only at end of phi2
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
            bank_q <= '0;
        else if (release_wr_i && !rwn_q && tgt_q == TGT_BANKREG)
            bank_q <= cpu_d_i;
    end

    // read data mux, sram passes through unregistered
    always_comb
    begin
        case (tgt_q)
            TGT_SRAM:    cpu_d_o = mem_d_i;
            TGT_BANKREG: cpu_d_o = bank_q;
            TGT_VIA:     cpu_d_o = via_rdata_i;
            default:     cpu_d_o = 8'hFF;   // open bus
        endcase
    end

    assign mem_d_o     = cpu_d_i;
    assign via_sel_o   = (tgt_q == TGT_VIA);
    assign via_reg_o   = via_reg_q;
    assign via_wdata_o = cpu_d_i;
    assign via_wr_o    = via_sel_o && !rwn_q && release_wr_i;    // one clock, in S5

endmodule

//--- rtl/simple_via.sv
`timescale 1ns/1ps

module simple_via import nora_bus_pkg::*, nora_cpu_pkg::*;
(
    input  logic     clk6x,
    input  logic     rst_n_i,
    // register access from bus controller
    input  logic     sel_i,
    input  logic     wr_i,         // single clock strobe
    input  via_reg_e reg_i,
    input  data_t    wdata_i,
    output data_t    rdata_o,
    // gpio port a
    input  data_t    pa_i,
    output data_t    pa_o,
    output data_t    pa_oe_o,      // 1 = output
    // gpio port b
    input  data_t    pb_i,
    output data_t    pb_o,
    output data_t    pb_oe_o
);

    data_t ora_q, orb_q;
    data_t ddra_q, ddrb_q;

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            ora_q  <= '0;
            orb_q  <= '0;
            ddra_q <= '0;   // all pins input after reset
            ddrb_q <= '0;
        end
        else if (sel_i && wr_i)
        begin
            case (reg_i)
                VIA_ORB:  orb_q  <= wdata_i;
                VIA_ORA:  ora_q  <= wdata_i;
                VIA_DDRB: ddrb_q <= wdata_i;
                default:  ddra_q <= wdata_i;
            endcase
        end
    end

    // orx read: own bit where driven, pin where input
    always_comb
    begin
        case (reg_i)
            VIA_ORB:  rdata_o = (orb_q & ddrb_q) | (pb_i & ~ddrb_q);
            VIA_ORA:  rdata_o = (ora_q & ddra_q) | (pa_i & ~ddra_q);
            VIA_DDRB: rdata_o = ddrb_q;
            default:  rdata_o = ddra_q;
        endcase
    end

    assign pa_o    = ora_q;
    assign pa_oe_o = ddra_q;
    assign pb_o    = orb_q;
    assign pb_oe_o = ddrb_q;

endmodule

//--- rtl/cpu_int_ctrl.sv
`timescale 1ns/1ps
`include "nora_consts.svh"

module cpu_int_ctrl import nora_cpu_pkg::*;
(
    input  logic clk6x,
    input  logic rst_n_i,
    input  logic attn_btn_i,     // active low, async
    input  logic vera_irq_n_i,
    output logic cpu_nmi_n_o,
    output logic cpu_irq_n_o
);

    btn_state_e             state_q;
    logic [`BTN_CNT_W-1:0]  cnt_q;
    logic                   btn_meta_q, btn_s_q;
    logic                   irq_meta_q;

    // two flop synchronizers, idle high
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            btn_meta_q  <= 1'b1;
            btn_s_q     <= 1'b1;
            irq_meta_q  <= 1'b1;
            cpu_irq_n_o <= 1'b1;
        end
        else
        begin
            btn_meta_q  <= attn_btn_i;
            btn_s_q     <= btn_meta_q;
            irq_meta_q  <= vera_irq_n_i;
            cpu_irq_n_o <= irq_meta_q;
        end
    end

    // cnt_q counts consecutive samples, or pulse clocks in BTN_PULSE
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            state_q     <= BTN_IDLE;
            cnt_q       <= '0;
            cpu_nmi_n_o <= 1'b1;
        end
        else
        begin
            case (state_q)
                BTN_IDLE:
                begin
                    cnt_q <= `BTN_CNT_W'(1);
                    if (!btn_s_q)
                        state_q <= BTN_DEBOUNCE;    // first low sample seen
                end
                BTN_DEBOUNCE:
                begin
                    if (btn_s_q)
                        state_q <= BTN_IDLE;        // glitch
                    else if (cnt_q == `BTN_CNT_W'(`DEBOUNCE_CYCLES - 1))
                    begin
                        state_q     <= BTN_PULSE;
                        cnt_q       <= `BTN_CNT_W'(1);
                        cpu_nmi_n_o <= 1'b0;
                    end
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                BTN_PULSE:
                begin
                    if (cnt_q == `BTN_CNT_W'(`NMI_PULSE_CYCLES))
                    begin
                        state_q     <= BTN_WAIT_RELEASE;
                        cnt_q       <= '0;
                        cpu_nmi_n_o <= 1'b1;
                    end
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                default:
                begin
                    // re-arm only after a stable release
                    if (!btn_s_q)
                        cnt_q <= '0;
                    else if (cnt_q == `BTN_CNT_W'(`DEBOUNCE_CYCLES - 1))
                        state_q <= BTN_IDLE;
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
            endcase
        end
    end

endmodule

//--- rtl/nora_top.sv
`timescale 1ns/1ps

module nora_top import nora_bus_pkg::*, nora_cpu_pkg::*;
(
    input  logic      clk6x,
    input  logic      rst_n_i,
    // cpu
    output logic      cpu_phi2_o,
    input  cpu_addr_t cpu_a_i,
    input  logic      cpu_rwn_i,
    input  data_t     cpu_d_i,
    output data_t     cpu_d_o,
    output logic      cpu_d_oe_o,
    output logic      cpu_nmi_n_o,
    output logic      cpu_irq_n_o,
    // memory bus
    output mem_ah_t   mem_ah_o,
    input  data_t     mem_d_i,
    output data_t     mem_d_o,
    output logic      mem_d_oe_o,
    output logic      sram_csn_o,
    output logic      vera_csn_o,
    output logic      mem_rdn_o,
    output logic      mem_wrn_o,
    // via gpio
    input  data_t     via_pa_i,
    output data_t     via_pa_o,
    output data_t     via_pa_oe_o,
    input  data_t     via_pb_i,
    output data_t     via_pb_o,
    output data_t     via_pb_oe_o,
    // misc
    input  logic      attn_btn_i,
    input  logic      vera_irq_n_i
);

    logic     latch_ad, setup_cs, release_wr, release_cs;
    logic     via_sel, via_wr;
    via_reg_e via_reg;
    data_t    via_wdata, via_rdata;

    phaser phaser_inst
    (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .cpu_phi2_o   (cpu_phi2_o),
        .latch_ad_o   (latch_ad),
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs)
    );

    bus_controller bus_controller_inst
    (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .latch_ad_i   (latch_ad),
        .setup_cs_i   (setup_cs),
        .release_wr_i (release_wr),
        .release_cs_i (release_cs),
        .cpu_a_i      (cpu_a_i),
        .cpu_rwn_i    (cpu_rwn_i),
        .cpu_d_i      (cpu_d_i),
        .cpu_d_o      (cpu_d_o),
        .cpu_d_oe_o   (cpu_d_oe_o),
        .mem_ah_o     (mem_ah_o),
        .mem_d_i      (mem_d_i),
        .mem_d_o      (mem_d_o),
        .mem_d_oe_o   (mem_d_oe_o),
        .sram_csn_o   (sram_csn_o),
        .vera_csn_o   (vera_csn_o),
        .mem_rdn_o    (mem_rdn_o),
        .mem_wrn_o    (mem_wrn_o),
        .via_reg_o    (via_reg),
        .via_wdata_o  (via_wdata),
        .via_wr_o     (via_wr),
        .via_sel_o    (via_sel),
        .via_rdata_i  (via_rdata)
    );

    simple_via simple_via_inst
    (
        .clk6x   (clk6x),
        .rst_n_i (rst_n_i),
        .sel_i   (via_sel),
        .wr_i    (via_wr),
        .reg_i   (via_reg),
        .wdata_i (via_wdata),
        .rdata_o (via_rdata),
        .pa_i    (via_pa_i),
        .pa_o    (via_pa_o),
        .pa_oe_o (via_pa_oe_o),
        .pb_i    (via_pb_i),
        .pb_o    (via_pb_o),
        .pb_oe_o (via_pb_oe_o)
    );

    cpu_int_ctrl cpu_int_ctrl_inst
    (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .attn_btn_i   (attn_btn_i),
        .vera_irq_n_i (vera_irq_n_i),
        .cpu_nmi_n_o  (cpu_nmi_n_o),
        .cpu_irq_n_o  (cpu_irq_n_o)
    );

endmodule

//--- tests/nora_top_sva.sv
`timescale 1ns/1ps

module nora_top_sva
(
    input logic clk6x,
    input logic rst_n_i,
    input logic cpu_phi2_o,
    input logic sram_csn_o,
    input logic vera_csn_o,
    input logic mem_wrn_o,
    input logic cpu_d_oe_o,
    input logic mem_d_oe_o
);

    // one device on the memory bus at a time
    a_one_cs: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        !(!sram_csn_o && !vera_csn_o)) else $error("both chip selects low");

    a_wr_in_cs: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        !mem_wrn_o |-> !sram_csn_o) else $error("write strobe without sram select");

    a_no_contention: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        !(cpu_d_oe_o && mem_d_oe_o)) else $error("cpu and memory data both driven");

    a_phi2_period: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        $rose(cpu_phi2_o) |-> ##6 $rose(cpu_phi2_o)) else $error("phi2 period not 6 clocks");

endmodule

bind nora_top nora_top_sva nora_top_sva_inst
(
    .clk6x      (clk6x),
    .rst_n_i    (rst_n_i),
    .cpu_phi2_o (cpu_phi2_o),
    .sram_csn_o (sram_csn_o),
    .vera_csn_o (vera_csn_o),
    .mem_wrn_o  (mem_wrn_o),
    .cpu_d_oe_o (cpu_d_oe_o),
    .mem_d_oe_o (mem_d_oe_o)
);

//--- tests/tb_nora_top.sv
`timescale 1ns/1ps
`include "nora_consts.svh"

module tb_nora_top import nora_bus_pkg::*, nora_cpu_pkg::*;
();

    // expected response of one cpu cycle
    typedef struct packed
    {
        bus_target_e tgt;
        mem_ah_t     ah;
        data_t       rd;
        logic        rom;
        logic        rwn;
        data_t       wd;
    } exp_t;

    localparam int N_CYCLES = 270;  // bus cycles plus button/irq time in cpu cycles
    localparam data_t PA_PINS = 8'h5A;
    localparam data_t PB_PINS = 8'hC3;

    logic clk6x = 1'b0;
    logic rst_n_i;
    cpu_addr_t cpu_a_i;
    logic cpu_rwn_i;
    data_t cpu_d_i, cpu_d_o, mem_d_i, mem_d_o;
    logic cpu_d_oe_o, mem_d_oe_o, cpu_phi2_o, cpu_nmi_n_o, cpu_irq_n_o;
    mem_ah_t mem_ah_o;
    logic sram_csn_o, vera_csn_o, mem_rdn_o, mem_wrn_o;
    data_t via_pa_i, via_pa_o, via_pa_oe_o, via_pb_i, via_pb_o, via_pb_oe_o;
    logic attn_btn_i, vera_irq_n_i;

    data_t sram_mem [0:511];    // one byte per 4k page is enough here
    exp_t  exp_q [$];
    bank_t bank_m;              // model of the bank register
    data_t ora_m, orb_m, ddra_m, ddrb_m;
    integer seed = 37;

    always #10 clk6x = ~clk6x;

    // sram answers while read strobe is low
    assign mem_d_i = mem_rdn_o ? 8'hFF : sram_mem[mem_ah_o];

    nora_top nora_top_inst
    (
        .clk6x(clk6x), .rst_n_i(rst_n_i), .cpu_phi2_o(cpu_phi2_o),
        .cpu_a_i(cpu_a_i), .cpu_rwn_i(cpu_rwn_i), .cpu_d_i(cpu_d_i),
        .cpu_d_o(cpu_d_o), .cpu_d_oe_o(cpu_d_oe_o),
        .cpu_nmi_n_o(cpu_nmi_n_o), .cpu_irq_n_o(cpu_irq_n_o),
        .mem_ah_o(mem_ah_o), .mem_d_i(mem_d_i), .mem_d_o(mem_d_o),
        .mem_d_oe_o(mem_d_oe_o), .sram_csn_o(sram_csn_o), .vera_csn_o(vera_csn_o),
        .mem_rdn_o(mem_rdn_o), .mem_wrn_o(mem_wrn_o),
        .via_pa_i(via_pa_i), .via_pa_o(via_pa_o), .via_pa_oe_o(via_pa_oe_o),
        .via_pb_i(via_pb_i), .via_pb_o(via_pb_o), .via_pb_oe_o(via_pb_oe_o),
        .attn_btn_i(attn_btn_i), .vera_irq_n_i(vera_irq_n_i)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act)
            stop_on_error($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_ah(input string name, input mem_ah_t exp, input mem_ah_t act);
        if (exp !== act)
            stop_on_error($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_on_error($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    // orx reads pin where direction bit is 0
    function automatic data_t via_read(input logic [1:0] sel);
        case (sel)
            2'd0:    via_read = (orb_m & ddrb_m) | (PB_PINS & ~ddrb_m);
            2'd1:    via_read = (ora_m & ddra_m) | (PA_PINS & ~ddra_m);
            2'd2:    via_read = ddrb_m;
            default: via_read = ddra_m;
        endcase
    endfunction

    function automatic exp_t expected_cycle(input cpu_addr_t a, input bank_t bank);
        exp_t  e;
        bank_t bm;
        e  = '0;
        bm = bank & 8'h7F;
        if (a == 16'h0000)
            e.tgt = TGT_BANKREG;
        else if (a[15:8] == 8'h9F)
        begin
            if (a[7:4] == 4'h0)
                e.tgt = TGT_VIA;
            else if (a[7:5] == 3'b001)  // 9F20..9F3F
                e.tgt = TGT_VERA;
            else
                e.tgt = TGT_NONE;
        end
        else
            e.tgt = TGT_SRAM;
        if (a[15:14] == 2'b11)
        begin
            e.ah  = {5'b01000, a[15:12]};   // rom window
            e.rom = 1'b1;
        end
        else if (a[15:13] == 3'b101)
            e.ah = {1'b1, bm[6:0], a[12]};
        else
            e.ah = {5'b00000, a[15:12]};
        case (e.tgt)
            TGT_SRAM:    e.rd = sram_mem[e.ah];
            TGT_BANKREG: e.rd = bank;
            TGT_VIA:     e.rd = via_read(a[1:0]);
            default:     e.rd = 8'hFF;
        endcase
        return e;
    endfunction

    // cpu model, drives after phi2 falls
    task automatic run_cycle(input cpu_addr_t a, input logic rwn, input data_t wd);
        exp_t e;
        @(negedge cpu_phi2_o);
        @(posedge clk6x);
        cpu_a_i   <= a;
        cpu_rwn_i <= rwn;
        cpu_d_i   <= wd;
        e = expected_cycle(a, bank_m);
        e.rwn = rwn;
        e.wd  = wd;
        exp_q.push_back(e);
        if (!rwn && e.tgt == TGT_BANKREG)
            bank_m = wd;
        if (!rwn && e.tgt == TGT_VIA)
        begin
            case (a[1:0])
                2'd0:    orb_m = wd;
                2'd1:    ora_m = wd;
                2'd2:    ddrb_m = wd;
                default: ddra_m = wd;
            endcase
        end
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0)
            @(posedge clk6x);
    endtask

    // compare in S5 of every driven cycle
    initial
    begin
        exp_t e;
        forever
        begin
            @(posedge cpu_phi2_o);
            @(posedge clk6x);
            @(posedge clk6x);
            @(negedge clk6x);
            if (exp_q.size() > 0)
            begin
                e = exp_q.pop_front();
                check_bit("sram_csn_o", e.tgt != TGT_SRAM, sram_csn_o);
                check_bit("vera_csn_o", e.tgt != TGT_VERA, vera_csn_o);
                check_ah("mem_ah_o", e.ah, mem_ah_o);
                check_bit("mem_rdn_o", !(e.rwn && (e.tgt == TGT_SRAM || e.tgt == TGT_VERA)),
                          mem_rdn_o);
                check_bit("mem_wrn_o", !(!e.rwn && e.tgt == TGT_SRAM && !e.rom), mem_wrn_o);
                check_bit("cpu_d_oe_o", e.rwn && e.tgt != TGT_VERA, cpu_d_oe_o);
                check_bit("mem_d_oe_o", !e.rwn && e.tgt == TGT_SRAM, mem_d_oe_o);
                if (e.rwn)
                    check_data("cpu_d_o", e.rd, cpu_d_o);
                if (!e.rwn && e.tgt == TGT_SRAM)
                    check_data("mem_d_o", e.wd, mem_d_o);
            end
        end
    end

    initial
    begin
        #(N_CYCLES * 6 * 20 + 2000);
        stop_on_error("timeout, the tests did not finish in time");
    end

    initial
    begin
        logic [31:0] r;
        cpu_addr_t   a;
        int          low_cnt, pulses;
        logic        prev;
        for (int i = 0; i < 512; i++)
            sram_mem[i] = data_t'((i * 37) ^ (i >> 3));
        rst_n_i = 1'b0;
        cpu_a_i = 16'h1000;
        cpu_rwn_i = 1'b1;
        cpu_d_i = 8'h00;
        via_pa_i = PA_PINS;
        via_pb_i = PB_PINS;
        attn_btn_i = 1'b1;
        vera_irq_n_i = 1'b1;
        bank_m = '0;
        {ora_m, orb_m, ddra_m, ddrb_m} = '0;
        repeat (2) @(posedge clk6x);
        rst_n_i <= 1'b1;

        // phi2 3 low / 3 high, quiet bus before first cycle
        for (int k = 1; k <= 12; k++)
        begin
            @(posedge clk6x);
            @(negedge clk6x);
            check_bit("cpu_phi2_o", (k % 6) >= 3, cpu_phi2_o);
            if (k <= 3)
            begin
                check_bit("sram_csn_o", 1'b1, sram_csn_o);
                check_bit("vera_csn_o", 1'b1, vera_csn_o);
                check_bit("mem_wrn_o", 1'b1, mem_wrn_o);
                check_bit("cpu_d_oe_o", 1'b0, cpu_d_oe_o);
            end
        end

        // banking, mask to 7F
        run_cycle(16'h0000, 1'b0, 8'hFF);
        run_cycle(16'hA000, 1'b1, 8'h00);
        run_cycle(16'hB123, 1'b1, 8'h00);
        run_cycle(16'h0000, 1'b1, 8'h00);

        // via registers and pins
        run_cycle(16'h9F03, 1'b0, 8'hF0);
        run_cycle(16'h9F01, 1'b0, 8'hA5);
        run_cycle(16'h9F02, 1'b0, 8'h0F);
        run_cycle(16'h9F00, 1'b0, 8'h3C);
        run_cycle(16'h9F01, 1'b1, 8'h00);
        run_cycle(16'h9F00, 1'b1, 8'h00);
        run_cycle(16'h9F03, 1'b1, 8'h00);
        wait_idle();
        check_data("via_pa_o", 8'hA5, via_pa_o);
        check_data("via_pa_oe_o", 8'hF0, via_pa_oe_o);
        check_data("via_pb_o", 8'h3C, via_pb_o);
        check_data("via_pb_oe_o", 8'h0F, via_pb_oe_o);

        // sram, unused io, rom
        run_cycle(16'h1234, 1'b1, 8'h00);
        run_cycle(16'h9F10, 1'b1, 8'h00);
        run_cycle(16'h8000, 1'b0, 8'h77);
        run_cycle(16'hE000, 1'b1, 8'h00);
        run_cycle(16'hC000, 1'b0, 8'h12);

        // random mix, every other one into the io page
        for (int n = 0; n < 200; n++)
        begin
            r = $random(seed);
            a = r[15:0];
            if (r[16])
                a = {8'h9F, r[7:0]};
            run_cycle(a, r[17], r[31:24]);
        end
        run_cycle(16'h1000, 1'b1, 8'h00);   // leave bus on a harmless read
        wait_idle();

        // short glitch, no nmi
        pulses = 0;
        prev = 1'b1;
        for (int i = 0; i < 60; i++)
        begin
            @(posedge clk6x);
            attn_btn_i <= (i >= 5);
            @(negedge clk6x);
            if (prev && !cpu_nmi_n_o)
                pulses++;
            prev = cpu_nmi_n_o;
        end
        if (pulses != 0)
            stop_on_error("NMI pulse seen after a 5 cycle button glitch");

        // long press, one pulse
        low_cnt = 0;
        for (int i = 0; i < 80; i++)
        begin
            @(posedge clk6x);
            attn_btn_i <= (i >= 40);
            @(negedge clk6x);
            if (prev && !cpu_nmi_n_o)
                pulses++;
            if (!cpu_nmi_n_o)
                low_cnt++;
            prev = cpu_nmi_n_o;
        end
        if (pulses != 1)
            stop_on_error($sformatf("expected one NMI pulse for a long press, saw %0d", pulses));
        if (low_cnt != `NMI_PULSE_CYCLES)
            stop_on_error($sformatf("NMI pulse was %0d cycles long", low_cnt));

        // irq through two flops
        @(posedge clk6x);
        vera_irq_n_i <= 1'b0;
        @(negedge clk6x);
        check_bit("cpu_irq_n_o", 1'b1, cpu_irq_n_o);
        @(negedge clk6x);
        check_bit("cpu_irq_n_o", 1'b1, cpu_irq_n_o);
        @(negedge clk6x);
        check_bit("cpu_irq_n_o", 1'b0, cpu_irq_n_o);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+common
common/nora_bus_pkg.sv
common/nora_cpu_pkg.sv
phaser/phaser.sv
busctrl/bus_controller.sv
rtl/simple_via.sv
rtl/cpu_int_ctrl.sv
rtl/nora_top.sv
tests/nora_top_sva.sv
tests/tb_nora_top.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top tb_nora_top -Mdir obj_dir
	./obj_dir/Vtb_nora_top

clean:
	rm -rf obj_dir
